//--- common/stepper_defines.svh
// widths and timing constants; MIN_PERIOD must stay at least twice STEP_PULSE_CYCLES
`ifndef STEPPER_DEFINES_SVH
`define STEPPER_DEFINES_SVH

// clocks the step pin stays high per pulse
`define STEP_PULSE_CYCLES 4'd8

// shortest legal step period in clocks
// twice the pulse width so pulses never overlap
`define MIN_PERIOD 16

// width of the step period register
`define SPEED_W 32

// driver datagram length, 8 address bits plus 32 data bits
`define SPI_FRAME_BITS 40

// system clocks per sck half period
`define SCK_HALF_CYCLES 4

`endif

//--- common/stepper_pkg.sv
// shared types for the motion peripheral; word map covers indices 0..9 only, rest read zero
`include "stepper_defines.svh"

package stepper_pkg;

  // opcode written to REG_CMD, low two bits of wdata
  typedef enum logic [1:0] {
    CMD_NOP  = 2'd0,
    CMD_MOVE = 2'd1,
    CMD_STOP = 2'd2,
    CMD_SPI  = 2'd3
  } cmd_op_t;

  // also the encoding of STATUS[1:0]
  typedef enum logic [1:0] {
    MS_IDLE = 2'd0,
    MS_RUN  = 2'd1,
    MS_SPI  = 2'd2
  } motion_state_t;

  // word index, taken from mem_addr[5:2]
  typedef enum logic [3:0] {
    REG_CTRL        = 4'd0,
    REG_SPEED       = 4'd1,
    REG_STEPS       = 4'd2,
    REG_CMD         = 4'd3,
    REG_STATUS      = 4'd4,
    REG_POSITION    = 4'd5,
    REG_SPI_TX      = 4'd6,
    REG_SPI_ADDR    = 4'd7,
    REG_SPI_RX      = 4'd8,
    REG_SPI_RX_STAT = 4'd9
  } reg_addr_t;

  typedef struct packed {
    logic                dir;
    logic [`SPEED_W-1:0] period;
    logic [31:0]         steps;
  } motion_cfg_t;

  // addr byte goes out first on the wire
  typedef struct packed {
    logic [7:0]  addr;
    logic [31:0] data;
  } spi_frame_t;

  typedef struct packed {
    logic        valid;
    reg_addr_t   addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
  } bus_req_t;

endpackage

//--- motion/motion_fsm.sv
// a MOVE with zero steps enters run and falls straight back on remaining_zero
`timescale 1ns/1ps

module motion_fsm (
  input  logic                 clk_in,
  input  logic                 rst,
  input  logic                 cmd_valid,
  input  stepper_pkg::cmd_op_t cmd,
  input  logic                 remaining_zero,
  input  logic                 spi_busy,
  output logic                 timer_en,
  output logic                 load,
  output logic                 abort,
  output logic                 spi_start,
  output logic                 motion_busy
);
  import stepper_pkg::*;

  motion_state_t state;
  motion_state_t state_next;

  always_ff @(posedge clk_in) begin
    if (rst) begin
      state <= MS_IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    load       = 1'b0;
    abort      = 1'b0;
    spi_start  = 1'b0;
    case (state)
      MS_IDLE: begin
        // stop and nop do nothing here
        if (cmd_valid && (cmd == CMD_MOVE)) begin
          load       = 1'b1;
          state_next = MS_RUN;
        end else if (cmd_valid && (cmd == CMD_SPI)) begin
          spi_start  = 1'b1;
          state_next = MS_SPI;
        end
      end
      MS_RUN: begin
        // stop wins over natural end
        if (cmd_valid && (cmd == CMD_STOP)) begin
          abort      = 1'b1;
          state_next = MS_IDLE;
        end else if (remaining_zero) begin
          // count already loaded one cycle earlier
          state_next = MS_IDLE;
        end
      end
      MS_SPI: begin
        // busy is set the cycle after spi_start
        if (!spi_busy) begin
          state_next = MS_IDLE;
        end
      end
      default: state_next = MS_IDLE;
    endcase
  end

  // timer runs for the whole move
  assign timer_en    = (state == MS_RUN);
  assign motion_busy = (state == MS_RUN);

  assert property (@(posedge clk_in) disable iff (rst) !(spi_start && load))
    else $error("spi_start and load together");

  // shifter must pick up every start
  assert property (@(posedge clk_in) disable iff (rst) spi_start |=> spi_busy)
    else $error("spi_start not followed by spi_busy");

endmodule

//--- motion/step_output.sv
// position wraps at 32 bits; abort drops queued steps but lets a running pulse finish
`timescale 1ns/1ps
`include "stepper_defines.svh"

module step_output (
  input  logic                     clk_in,
  input  logic                     rst,
  input  logic                     load,
  input  logic                     abort,
  input  logic                     tick,
  input  stepper_pkg::motion_cfg_t cfg,
  output logic                     step,
  output logic                     dir,
  output logic                     remaining_zero,
  output logic signed [31:0]       position
);

  logic [31:0] remaining;
  logic [3:0]  pulse_cnt;
  logic        start;

  // abort also kills a tick in the same cycle
  assign start = tick && !abort && (remaining != 32'd0);

  // done only once the last pulse has dropped
  assign remaining_zero = (remaining == 32'd0) && !step;

  // count and position
  always_ff @(posedge clk_in) begin
    if (rst) begin
      dir       <= 1'b0;
      remaining <= 32'd0;
      position  <= 32'sd0;
    end else if (load) begin
      dir       <= cfg.dir;
      remaining <= cfg.steps;
    end else if (abort) begin
      remaining <= 32'd0;
    end else if (start) begin
      remaining <= remaining - 32'd1;
      // dir low counts up
      if (dir) begin
        position <= position - 32'sd1;
      end else begin
        position <= position + 32'sd1;
      end
    end
  end

  // pulse stretcher
  always_ff @(posedge clk_in) begin
    if (rst) begin
      step      <= 1'b0;
      pulse_cnt <= 4'd0;
    end else if (start) begin
      step      <= 1'b1;
      pulse_cnt <= `STEP_PULSE_CYCLES;
    end else if (step) begin
      if (pulse_cnt == 4'd1) begin
        step <= 1'b0;
      end
      pulse_cnt <= pulse_cnt - 4'd1;
    end
  end

  // period clamp in the register bank keeps ticks apart
  assert property (@(posedge clk_in) disable iff (rst) !(tick && step))
    else $error("step tick during active pulse");

endmodule

//--- motion/step_timer.sv
// period is sampled while disabled and at each reload, so changes mid-move apply next step
`timescale 1ns/1ps
`include "stepper_defines.svh"

module step_timer (
  input  logic                clk_in,
  input  logic                rst,
  input  logic                timer_en,
  input  logic [`SPEED_W-1:0] period,
  output logic                tick
);

  logic [`SPEED_W-1:0] cnt;

  always_ff @(posedge clk_in) begin
    if (rst) begin
      cnt  <= period;
      tick <= 1'b0;
    end else if (!timer_en) begin
      // idle, hold the full period for the first step
      cnt  <= period;
      tick <= 1'b0;
    end else begin
      // tick is registered, one cycle after cnt hits one
      tick <= (cnt == `SPEED_W'(1));
      if (cnt == `SPEED_W'(1)) begin
        cnt <= period;
      end else begin
        cnt <= cnt - `SPEED_W'(1);
      end
    end
  end

endmodule

//--- project.f
+incdir+common
common/stepper_pkg.sv
source/bus_regs.sv
motion/motion_fsm.sv
motion/step_timer.sv
motion/step_output.sv
spi/spi_shifter.sv
source/stepper_ctrl_top.sv
tb/stepper_tb.sv

//--- run.sh
#!/bin/sh
# compile with Verilator, run, and fail when the log holds the fail message
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --timescale 1ns/1ps -f project.f --top-module stepper_tb \
  -o stepper_sim > build.log 2>&1 \
  && ./obj_dir/stepper_sim > sim.log 2>&1 \
  || { echo "build or simulation error, see build.log and sim.log"; exit 1; }
grep -q '\*\* FAIL \*\*' sim.log && { echo "simulation failed, see sim.log"; exit 1; }
echo "simulation passed"
exit 0

//--- source/bus_regs.sv
// word-wide writes only, byte strobes just flag a write; CPU must hold valid until ready
`timescale 1ns/1ps
`include "stepper_defines.svh"

module bus_regs (
  input  logic                     clk_in,
  input  logic                     rst,
  input  stepper_pkg::bus_req_t    req,
  output logic [31:0]              rdata,
  output logic                     ready,
  output stepper_pkg::motion_cfg_t cfg,
  output logic                     drv_en,
  output logic                     cmd_valid,
  output stepper_pkg::cmd_op_t     cmd,
  output stepper_pkg::spi_frame_t  spi_tx,
  input  logic                     motion_busy,
  input  logic                     spi_busy,
  input  logic signed [31:0]       position,
  input  stepper_pkg::spi_frame_t  spi_rx
);
  import stepper_pkg::*;

  logic        access;
  logic        wr;
  logic [31:0] rd_mux;

  // first cycle of a request only, ready blocks the second
  assign access = req.valid && !ready;
  assign wr     = access && (req.wstrb != 4'b0000);

  // read-back mux
  always_comb begin
    case (req.addr)
      REG_CTRL:        rd_mux = {30'd0, cfg.dir, drv_en};
      REG_SPEED:       rd_mux = 32'(cfg.period);
      REG_STEPS:       rd_mux = cfg.steps;
      REG_CMD:         rd_mux = {30'd0, cmd};
      // same coding as motion_state_t
      REG_STATUS:      rd_mux = {30'd0, spi_busy, motion_busy};
      REG_POSITION:    rd_mux = position;
      REG_SPI_TX:      rd_mux = spi_tx.data;
      REG_SPI_ADDR:    rd_mux = {24'd0, spi_tx.addr};
      REG_SPI_RX:      rd_mux = spi_rx.data;
      // status byte the driver shifts back during the address phase
      REG_SPI_RX_STAT: rd_mux = {24'd0, spi_rx.addr};
      default:         rd_mux = 32'd0;
    endcase
  end

  // control registers
  always_ff @(posedge clk_in) begin
    if (rst) begin
      ready      <= 1'b0;
      cmd_valid  <= 1'b0;
      cmd        <= CMD_NOP;
      drv_en     <= 1'b0;
      cfg.dir    <= 1'b0;
      cfg.period <= `SPEED_W'(`MIN_PERIOD);
      cfg.steps  <= 32'd0;
    end else begin
      ready     <= access;
      cmd_valid <= wr && (req.addr == REG_CMD);
      if (wr) begin
        case (req.addr)
          REG_CTRL: begin
            drv_en  <= req.wdata[0];
            cfg.dir <= req.wdata[1];
          end
          REG_SPEED: begin
            // too short a period would overlap pulses
            if (req.wdata < 32'(`MIN_PERIOD)) begin
              cfg.period <= `SPEED_W'(`MIN_PERIOD);
            end else begin
              cfg.period <= `SPEED_W'(req.wdata);
            end
          end
          REG_STEPS: cfg.steps <= req.wdata;
          REG_CMD:   cmd <= cmd_op_t'(req.wdata[1:0]);
          // read-only words fall through
          default: ;
        endcase
      end
    end
  end

  // read data and spi payload
  always_ff @(posedge clk_in) begin
    if (access) begin
      rdata <= rd_mux;
    end
    if (wr && (req.addr == REG_SPI_TX)) begin
      spi_tx.data <= req.wdata;
    end
    if (wr && (req.addr == REG_SPI_ADDR)) begin
      spi_tx.addr <= req.wdata[7:0];
    end
  end

  // one ready per access
  assert property (@(posedge clk_in) disable iff (rst) ready |=> !ready)
    else $error("bus ready held for two cycles");

endmodule

//--- source/stepper_ctrl_top.sv
// bus decode uses mem_addr[5:2] only; caller selects this block with mem_valid
`timescale 1ns/1ps

module stepper_ctrl_top (
  input  logic        clk_in,
  input  logic        rst,
  input  logic        mem_valid,
  input  logic [31:0] mem_addr,
  input  logic [31:0] mem_wdata,
  input  logic [3:0]  mem_wstrb,
  output logic [31:0] mem_rdata,
  output logic        mem_ready,
  output logic        step,
  output logic        dir,
  output logic        drv_en,
  output logic        sck,
  output logic        cs_n,
  output logic        mosi,
  input  logic        miso
);
  import stepper_pkg::*;

  bus_req_t           req;
  motion_cfg_t        cfg;
  cmd_op_t            cmd;
  spi_frame_t         spi_tx;
  spi_frame_t         spi_rx;
  logic               cmd_valid;
  logic               timer_en;
  logic               load;
  logic               abort;
  logic               spi_start;
  logic               motion_busy;
  logic               spi_busy;
  logic               remaining_zero;
  logic               tick;
  logic signed [31:0] position;

  // pack the cpu bus, word index from byte address
  assign req.valid = mem_valid;
  assign req.addr  = reg_addr_t'(mem_addr[5:2]);
  assign req.wdata = mem_wdata;
  assign req.wstrb = mem_wstrb;

  bus_regs regs (
    .clk_in(clk_in), .rst(rst), .req(req), .rdata(mem_rdata), .ready(mem_ready),
    .cfg(cfg), .drv_en(drv_en), .cmd_valid(cmd_valid), .cmd(cmd), .spi_tx(spi_tx),
    .motion_busy(motion_busy), .spi_busy(spi_busy), .position(position), .spi_rx(spi_rx)
  );

  motion_fsm fsm (
    .clk_in(clk_in), .rst(rst), .cmd_valid(cmd_valid), .cmd(cmd),
    .remaining_zero(remaining_zero), .spi_busy(spi_busy), .timer_en(timer_en),
    .load(load), .abort(abort), .spi_start(spi_start), .motion_busy(motion_busy)
  );

  step_timer timer (
    .clk_in(clk_in), .rst(rst), .timer_en(timer_en), .period(cfg.period), .tick(tick)
  );

  step_output stepper (
    .clk_in(clk_in), .rst(rst), .load(load), .abort(abort), .tick(tick), .cfg(cfg),
    .step(step), .dir(dir), .remaining_zero(remaining_zero), .position(position)
  );

  spi_shifter spi (
    .clk_in(clk_in), .rst(rst), .spi_start(spi_start), .tx(spi_tx), .miso(miso),
    .rx(spi_rx), .spi_busy(spi_busy), .sck(sck), .cs_n(cs_n), .mosi(mosi)
  );

endmodule

//--- spi/spi_shifter.sv
// mode 3 only, MSB first; mosi is held low while cs_n is high
`timescale 1ns/1ps
`include "stepper_defines.svh"

module spi_shifter (
  input  logic                    clk_in,
  input  logic                    rst,
  input  logic                    spi_start,
  input  stepper_pkg::spi_frame_t tx,
  input  logic                    miso,
  output stepper_pkg::spi_frame_t rx,
  output logic                    spi_busy,
  output logic                    sck,
  output logic                    cs_n,
  output logic                    mosi
);
  import stepper_pkg::*;

  localparam int FRAME  = `SPI_FRAME_BITS;
  localparam int HALF   = `SCK_HALF_CYCLES;
  localparam int BIT_W  = $clog2(FRAME + 1);
  localparam int HALF_W = $clog2(HALF + 1);

  logic [FRAME-1:0]  tx_sr;
  logic [FRAME-1:0]  rx_sr;
  logic [BIT_W-1:0]  bit_cnt;
  logic [HALF_W-1:0] half_cnt;

  // control side
  always_ff @(posedge clk_in) begin
    if (rst) begin
      spi_busy <= 1'b0;
      cs_n     <= 1'b1;
      sck      <= 1'b1;
      bit_cnt  <= '0;
      half_cnt <= '0;
    end else if (!spi_busy) begin
      if (spi_start) begin
        spi_busy <= 1'b1;
        cs_n     <= 1'b0;
        bit_cnt  <= '0;
        half_cnt <= '0;
      end
    end else if (half_cnt == HALF_W'(HALF - 1)) begin
      half_cnt <= '0;
      if (bit_cnt == BIT_W'(FRAME)) begin
        // last half period after the final rising edge
        spi_busy <= 1'b0;
        cs_n     <= 1'b1;
      end else if (sck) begin
        sck <= 1'b0;
      end else begin
        sck     <= 1'b1;
        bit_cnt <= bit_cnt + BIT_W'(1);
      end
    end else begin
      half_cnt <= half_cnt + HALF_W'(1);
    end
  end

  // data side
  always_ff @(posedge clk_in) begin
    if (!spi_busy && spi_start) begin
      tx_sr <= tx;
    end else if (spi_busy && (half_cnt == HALF_W'(HALF - 1)) && (bit_cnt != BIT_W'(FRAME))) begin
      if (sck) begin
        // falling edge, first one leaves the MSB in place
        if (bit_cnt != '0) begin
          tx_sr <= {tx_sr[FRAME-2:0], 1'b0};
        end
      end else begin
        // rising edge samples miso
        rx_sr <= {rx_sr[FRAME-2:0], miso};
      end
    end
  end

  assign mosi = tx_sr[FRAME-1] & ~cs_n;
  assign rx   = spi_frame_t'(rx_sr);

endmodule

//--- tb/stepper_tb.sv
// miso loops back mosi one sck period late, so the received frame is the sent one shifted right
`timescale 1ns/1ps
`include "stepper_defines.svh"

module stepper_tb;
  import stepper_pkg::*;

  localparam int MAX_STEPS  = 6;
  localparam int MAX_PERIOD = 40;
  // four moves with the stopped one, one spi frame, then bus and polling slack
  localparam int TIMEOUT_CYCLES = 4 * (MAX_STEPS + 2) * MAX_PERIOD
    + (2 * `SPI_FRAME_BITS + 2) * `SCK_HALF_CYCLES + 2000;

  logic        clk_in = 1'b0;
  logic        rst;
  logic        mem_valid;
  logic [31:0] mem_addr;
  logic [31:0] mem_wdata;
  logic [3:0]  mem_wstrb;
  logic [31:0] mem_rdata;
  logic        mem_ready;
  logic        step;
  logic        dir;
  logic        drv_en;
  logic        sck;
  logic        cs_n;
  logic        mosi;
  logic        miso = 1'b0;

  logic [31:0] cyc = 32'd0;
  logic [31:0] ready_cyc;
  int          checks = 0;
  int          errors = 0;
  int          tests = 0;
  int          seed;
  // step monitor state
  logic [31:0] rise_q[$];
  logic [31:0] width_q[$];
  logic [31:0] high_cnt = 32'd0;
  logic        step_prev = 1'b0;
  // spi loopback state
  logic        sck_prev = 1'b1;
  logic [31:0] sck_rises = 32'd0;
  logic [39:0] mosi_cap;
  // move history for the position model
  logic        hist_dir[$];
  logic [31:0] hist_steps[$];

  stepper_ctrl_top uut (
    .clk_in(clk_in), .rst(rst), .mem_valid(mem_valid), .mem_addr(mem_addr),
    .mem_wdata(mem_wdata), .mem_wstrb(mem_wstrb), .mem_rdata(mem_rdata),
    .mem_ready(mem_ready), .step(step), .dir(dir), .drv_en(drv_en), .sck(sck),
    .cs_n(cs_n), .mosi(mosi), .miso(miso)
  );

  always #5 clk_in = ~clk_in;

  always @(posedge clk_in) begin
    cyc <= cyc + 32'd1;
  end

  always @(negedge clk_in) begin
    if (cyc > 32'(TIMEOUT_CYCLES)) begin
      $display("timeout: no result after %0d cycles, run stopped", cyc);
      $display("** FAIL **");
      $finish;
    end
  end

  // rising edge times and high widths of step
  always @(negedge clk_in) begin
    if (step && !step_prev) begin
      rise_q.push_back(cyc);
    end
    if (step) begin
      high_cnt = high_cnt + 32'd1;
    end else if (step_prev) begin
      width_q.push_back(high_cnt);
      high_cnt = 32'd0;
    end
    step_prev = step;
  end

  // capture mosi on sck rise, present it on miso for the next rise
  always @(negedge clk_in) begin
    if (cs_n) begin
      miso = 1'b0;
    end else if (sck && !sck_prev) begin
      mosi_cap  = {mosi_cap[38:0], mosi};
      sck_rises = sck_rises + 32'd1;
      miso      = mosi;
    end
    sck_prev = sck;
  end

  // signed sum of all moves, dir high counts down
  function automatic logic [31:0] predict_position();
    logic [31:0] sum;
    sum = 32'd0;
    foreach (hist_steps[i]) begin
      if (hist_dir[i]) begin
        sum = sum - hist_steps[i];
      end else begin
        sum = sum + hist_steps[i];
      end
    end
    return sum;
  endfunction

  task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks = checks + 1;
    if (got !== exp) begin
      errors = errors + 1;
      $display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_frame(input string what, input spi_frame_t got, input spi_frame_t exp);
    checks = checks + 1;
    if (got !== exp) begin
      errors = errors + 1;
      $display("FAIL %0t: %s is %h_%h, expected %h_%h", $time, what,
               got.addr, got.data, exp.addr, exp.data);
    end
  endtask

  task automatic check_state(input string what, input motion_state_t got,
                             input motion_state_t exp);
    checks = checks + 1;
    if (got !== exp) begin
      errors = errors + 1;
      $display("FAIL %0t: %s is %s (%0d), expected %s", $time, what, got.name(), got,
               exp.name());
    end
  endtask

  task automatic report_test(input string name, input int err_before);
    tests = tests + 1;
    if (errors == err_before) begin
      $display("test %0d %s: ok", tests, name);
    end else begin
      $display("test %0d %s: %0d errors", tests, name, errors - err_before);
    end
  endtask

  // valid held until ready, dropped in the cycle after it
  task automatic bus_access(input logic [3:0] word, input logic [31:0] wdata,
                            input logic [3:0] wstrb, output logic [31:0] rdata);
    @(negedge clk_in);
    mem_valid = 1'b1;
    mem_addr  = {26'd0, word, 2'b00};
    mem_wdata = wdata;
    mem_wstrb = wstrb;
    @(negedge clk_in);
    while (!mem_ready) begin
      @(negedge clk_in);
    end
    rdata     = mem_rdata;
    ready_cyc = cyc;
    @(negedge clk_in);
    mem_valid = 1'b0;
    mem_wstrb = 4'd0;
  endtask

  task automatic bus_write(input logic [3:0] word, input logic [31:0] wdata);
    logic [31:0] unused;
    bus_access(word, wdata, 4'hf, unused);
  endtask

  task automatic bus_read(input logic [3:0] word, output logic [31:0] rdata);
    bus_access(word, 32'd0, 4'd0, rdata);
  endtask

  task automatic wait_idle();
    logic [31:0] st;
    st = 32'd3;
    while (st[1:0] != 2'd0) begin
      bus_read(REG_STATUS, st);
    end
  endtask

  task automatic run_move(input logic mdir, input logic [31:0] steps, input logic [31:0] period);
    logic [31:0] rd;
    logic [31:0] start_cyc;
    int          rbase;
    int          wbase;
    rbase = rise_q.size();
    wbase = width_q.size();
    bus_write(REG_CTRL, {30'd0, mdir, 1'b1});
    bus_write(REG_SPEED, period);
    bus_write(REG_STEPS, steps);
    bus_write(REG_CMD, 32'(CMD_MOVE));
    start_cyc = ready_cyc;
    bus_read(REG_STATUS, rd);
    check_state("status during move", motion_state_t'(rd[1:0]), MS_RUN);
    wait_idle();
    check_word("step count", 32'(rise_q.size() - rbase), steps);
    if (rise_q.size() > rbase) begin
      check_word("first step latency", rise_q[rbase] - start_cyc, period + 32'd2);
    end
    for (int i = rbase + 1; i < rise_q.size(); i++) begin
      check_word("step interval", rise_q[i] - rise_q[i-1], period);
    end
    for (int i = wbase; i < width_q.size(); i++) begin
      check_word("pulse width", width_q[i], 32'(`STEP_PULSE_CYCLES));
    end
    check_word("dir pin", {31'd0, dir}, {31'd0, mdir});
    hist_dir.push_back(mdir);
    hist_steps.push_back(steps);
    bus_read(REG_POSITION, rd);
    check_word("position", rd, predict_position());
  endtask

  initial begin
    logic [31:0] rd;
    logic [31:0] steps;
    logic [31:0] period;
    logic [31:0] stop_cyc;
    logic [31:0] late;
    logic [31:0] rise_base;
    int          e0;
    int          rbase;
    int          wbase;
    spi_frame_t  tx;
    spi_frame_t  rx;
    seed      = 32'haf4c_406c;
    rst       = 1'b1;
    mem_valid = 1'b0;
    mem_addr  = 32'd0;
    mem_wdata = 32'd0;
    mem_wstrb = 4'd0;
    repeat (10) @(negedge clk_in);
    rst = 1'b0;

    e0 = errors;
    check_word("step after reset", {31'd0, step}, 32'd0);
    check_word("cs_n after reset", {31'd0, cs_n}, 32'd1);
    check_word("sck after reset", {31'd0, sck}, 32'd1);
    check_word("drv_en after reset", {31'd0, drv_en}, 32'd0);
    check_word("mem_ready after reset", {31'd0, mem_ready}, 32'd0);
    bus_read(REG_STATUS, rd);
    check_state("status after reset", motion_state_t'(rd[1:0]), MS_IDLE);
    check_word("status word after reset", rd, 32'd0);
    bus_read(REG_POSITION, rd);
    check_word("position after reset", rd, 32'd0);
    // short period is clamped
    bus_write(REG_SPEED, 32'd5);
    bus_read(REG_SPEED, rd);
    check_word("clamped speed", rd, 32'(`MIN_PERIOD));
    bus_write(REG_SPEED, 32'd100);
    bus_read(REG_SPEED, rd);
    check_word("speed", rd, 32'd100);
    bus_write(REG_STEPS, 32'h1234_5678);
    bus_read(REG_STEPS, rd);
    check_word("steps", rd, 32'h1234_5678);
    bus_write(REG_CTRL, 32'd3);
    bus_read(REG_CTRL, rd);
    check_word("ctrl", rd, 32'd3);
    check_word("drv_en pin", {31'd0, drv_en}, 32'd1);
    bus_write(REG_SPI_TX, 32'hdead_beef);
    bus_read(REG_SPI_TX, rd);
    check_word("spi tx", rd, 32'hdead_beef);
    bus_write(REG_SPI_ADDR, 32'h0000_00a5);
    bus_read(REG_SPI_ADDR, rd);
    check_word("spi addr", rd, 32'h0000_00a5);
    // read-only and unmapped words
    bus_write(REG_STATUS, 32'hffff_ffff);
    bus_read(REG_STATUS, rd);
    check_word("status after write", rd, 32'd0);
    bus_read(4'd12, rd);
    check_word("unmapped word", rd, 32'd0);
    report_test("reset and read-back", e0);

    e0 = errors;
    steps  = 32'd1 + ($unsigned($random(seed)) % 32'(MAX_STEPS));
    period = 32'(`MIN_PERIOD)
      + ($unsigned($random(seed)) % 32'(MAX_PERIOD - `MIN_PERIOD + 1));
    run_move(1'b0, steps, period);
    report_test("move timing", e0);

    e0 = errors;
    steps  = 32'd1 + ($unsigned($random(seed)) % 32'(MAX_STEPS));
    period = 32'(`MIN_PERIOD)
      + ($unsigned($random(seed)) % 32'(MAX_PERIOD - `MIN_PERIOD + 1));
    run_move(1'b0, steps, period);
    steps  = 32'd1 + ($unsigned($random(seed)) % 32'(MAX_STEPS));
    period = 32'(`MIN_PERIOD)
      + ($unsigned($random(seed)) % 32'(MAX_PERIOD - `MIN_PERIOD + 1));
    run_move(1'b1, steps, period);
    report_test("direction and position", e0);

    e0 = errors;
    rbase = rise_q.size();
    wbase = width_q.size();
    bus_write(REG_CTRL, 32'd1);
    bus_write(REG_SPEED, 32'd20);
    bus_write(REG_STEPS, 32'd50);
    bus_write(REG_CMD, 32'(CMD_MOVE));
    while (rise_q.size() < rbase + 2) begin
      @(negedge clk_in);
    end
    // spi request while moving is dropped
    bus_write(REG_CMD, 32'(CMD_SPI));
    bus_read(REG_STATUS, rd);
    check_state("status after spi during move", motion_state_t'(rd[1:0]), MS_RUN);
    check_word("cs_n after spi during move", {31'd0, cs_n}, 32'd1);
    bus_write(REG_CMD, 32'(CMD_STOP));
    stop_cyc = ready_cyc;
    wait_idle();
    repeat (60) @(negedge clk_in);
    late = 32'd0;
    for (int i = rbase; i < rise_q.size(); i++) begin
      if (rise_q[i] > stop_cyc) begin
        late = late + 32'd1;
      end
    end
    check_word("steps begun after stop", late, 32'd0);
    check_word("pulses completed", 32'(width_q.size() - wbase), 32'(rise_q.size() - rbase));
    for (int i = wbase; i < width_q.size(); i++) begin
      check_word("pulse width at stop", width_q[i], 32'(`STEP_PULSE_CYCLES));
    end
    hist_dir.push_back(1'b0);
    hist_steps.push_back(32'(rise_q.size() - rbase));
    bus_read(REG_POSITION, rd);
    check_word("position after stop", rd, predict_position());
    report_test("stop", e0);

    e0 = errors;
    tx.addr = 8'($random(seed));
    tx.data = $random(seed);
    bus_write(REG_SPI_ADDR, {24'd0, tx.addr});
    bus_write(REG_SPI_TX, tx.data);
    rise_base = sck_rises;
    rbase     = rise_q.size();
    bus_write(REG_CMD, 32'(CMD_SPI));
    bus_read(REG_STATUS, rd);
    check_state("status during spi", motion_state_t'(rd[1:0]), MS_SPI);
    // move request while shifting is dropped
    bus_write(REG_CMD, 32'(CMD_MOVE));
    wait_idle();
    check_word("cs_n after spi", {31'd0, cs_n}, 32'd1);
    check_word("sck rises", sck_rises - rise_base, 32'(`SPI_FRAME_BITS));
    check_frame("mosi frame", spi_frame_t'(mosi_cap), tx);
    bus_read(REG_SPI_RX, rd);
    rx.data = rd;
    bus_read(REG_SPI_RX_STAT, rd);
    rx.addr = rd[7:0];
    check_frame("received frame", rx, spi_frame_t'({1'b0, tx[39:1]}));
    check_word("steps during spi", 32'(rise_q.size() - rbase), 32'd0);
    report_test("spi transfer", e0);

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule
